// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := rv32_core_tb
FILELIST := vlog.f
BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
SOURCES  := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf $(BUILD)

// ==== logic/core_cfg_pkg.sv ====
`default_nettype none

package core_cfg_pkg;

  // first fetch address after reset
  localparam rv_isa_pkg::word_t reset_pc = 32'h8000_0000;

  // integer register count, x0 included
  localparam int num_regs = 32;

  // sequential pc step, no compressed instructions
  localparam rv_isa_pkg::word_t inst_bytes = 32'd4;

endpackage

`default_nettype wire

// ==== logic/rv32_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_core (
  input  wire                clk,
  input  wire                reset,
  input  rv_isa_pkg::inst_t  inst,
  output rv_isa_pkg::word_t  pc,
  output logic               halt
);

  // decode outputs
  rv_isa_pkg::op_t      op;
  rv_isa_pkg::reg_idx_t rd;
  rv_isa_pkg::reg_idx_t rs1;
  rv_isa_pkg::word_t    imm;

  // register read
  rv_isa_pkg::word_t rs1_data;

  // execute results
  logic              wb_en;
  rv_isa_pkg::word_t wb_data;
  logic              jump;
  rv_isa_pkg::word_t target;

  // sequential pc from the pc unit
  rv_isa_pkg::word_t pc_plus4;

  // decode
  rv_decode u_decode (
    .inst (inst),
    .op   (op),
    .rd   (rd),
    .rs1  (rs1),
    .imm  (imm)
  );

  // register read, written back at the end of the cycle
  rv_regfile u_regfile (
    .clk      (clk),
    .rs1      (rs1),
    .rs1_data (rs1_data),
    .wen      (wb_en),
    .waddr    (rd),
    .wdata    (wb_data)
  );

  // execute
  rv_execute u_execute (
    .op       (op),
    .rs1_data (rs1_data),
    .imm      (imm),
    .pc       (pc),
    .pc_plus4 (pc_plus4),
    .wb_en    (wb_en),
    .wb_data  (wb_data),
    .jump     (jump),
    .target   (target)
  );

  // next pc and halt
  rv_pc_unit u_pc_unit (
    .clk      (clk),
    .reset    (reset),
    .op       (op),
    .jump     (jump),
    .target   (target),
    .pc       (pc),
    .pc_plus4 (pc_plus4),
    .halt     (halt)
  );

endmodule

`default_nettype wire

// ==== logic/rv_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_decode (
  input  rv_isa_pkg::inst_t    inst,
  output rv_isa_pkg::op_t      op,
  output rv_isa_pkg::reg_idx_t rd,
  output rv_isa_pkg::reg_idx_t rs1,
  output rv_isa_pkg::word_t    imm
);

  rv_isa_pkg::opcode_t opcode;
  rv_isa_pkg::funct3_t funct3;

  // immediates of each format, sign extended
  rv_isa_pkg::word_t imm_i;
  rv_isa_pkg::word_t imm_u;
  rv_isa_pkg::word_t imm_j;

  // fixed field positions
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];

  // i type, 12 bits from the top
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  // u type, already in the upper 20 bits
  assign imm_u = {inst[31:12], 12'h000};
  // j type, scrambled offset with bit 0 always zero
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // operation class
  always_comb begin
    op = rv_isa_pkg::op_nop;
    case (opcode)
      rv_isa_pkg::opc_op_imm: begin
        // only addi among the op-imm group
        if (funct3 == rv_isa_pkg::f3_addi) begin
          op = rv_isa_pkg::op_addi;
        end
      end
      rv_isa_pkg::opc_lui:   op = rv_isa_pkg::op_lui;
      rv_isa_pkg::opc_auipc: op = rv_isa_pkg::op_auipc;
      rv_isa_pkg::opc_jal:   op = rv_isa_pkg::op_jal;
      rv_isa_pkg::opc_jalr:  op = rv_isa_pkg::op_jalr;
      rv_isa_pkg::opc_system: begin
        // ecall and csr words fall through as nop
        if (inst == rv_isa_pkg::ebreak_inst) begin
          op = rv_isa_pkg::op_ebreak;
        end
      end
      // loads, stores, branches, r type and the rest
      default: op = rv_isa_pkg::op_nop;
    endcase
  end

  // immediate for the decoded class
  always_comb begin
    case (op)
      rv_isa_pkg::op_addi,
      rv_isa_pkg::op_jalr:  imm = imm_i;
      rv_isa_pkg::op_lui,
      rv_isa_pkg::op_auipc: imm = imm_u;
      rv_isa_pkg::op_jal:   imm = imm_j;
      // no adder use, keep it quiet
      default:              imm = '0;
    endcase
  end

endmodule

`default_nettype wire

// ==== logic/rv_execute.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_execute (
  input  rv_isa_pkg::op_t   op,
  input  rv_isa_pkg::word_t rs1_data,
  input  rv_isa_pkg::word_t imm,
  input  rv_isa_pkg::word_t pc,
  input  rv_isa_pkg::word_t pc_plus4,
  output logic              wb_en,
  output rv_isa_pkg::word_t wb_data,
  output logic              jump,
  output rv_isa_pkg::word_t target
);

  // shared adder, imm is always the second operand
  rv_isa_pkg::word_t add_a;
  rv_isa_pkg::word_t sum;

  // first operand
  always_comb begin
    case (op)
      rv_isa_pkg::op_addi,
      rv_isa_pkg::op_jalr:  add_a = rs1_data;
      rv_isa_pkg::op_auipc,
      rv_isa_pkg::op_jal:   add_a = pc;
      // lui adds its upper immediate to zero
      default:              add_a = '0;
    endcase
  end

  assign sum = add_a + imm;

  // both jumps redirect the pc
  assign jump = (op == rv_isa_pkg::op_jal) || (op == rv_isa_pkg::op_jalr);

  // jalr drops bit 0 of the sum
  assign target = {sum[31:1], sum[0] & (op != rv_isa_pkg::op_jalr)};

  // register write for every kept class except ebreak
  always_comb begin
    case (op)
      rv_isa_pkg::op_addi,
      rv_isa_pkg::op_lui,
      rv_isa_pkg::op_auipc,
      rv_isa_pkg::op_jal,
      rv_isa_pkg::op_jalr: wb_en = 1'b1;
      default:             wb_en = 1'b0;
    endcase
  end

  // link value for jumps, sum otherwise
  assign wb_data = jump ? pc_plus4 : sum;

endmodule

`default_nettype wire

// ==== logic/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

  // base data width of rv32
  localparam int xlen = 32;

  // instruction field widths
  localparam int opcode_w  = 7;
  localparam int reg_idx_w = 5;
  localparam int funct3_w  = 3;

  // data or address word
  typedef logic [xlen-1:0] word_t;
  // raw instruction word, same width as a data word on rv32
  typedef logic [xlen-1:0] inst_t;
  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [opcode_w-1:0]  opcode_t;
  typedef logic [funct3_w-1:0]  funct3_t;

  // major opcodes of the classes this core knows
  localparam opcode_t opc_op_imm = 7'b001_0011;
  localparam opcode_t opc_auipc  = 7'b001_0111;
  localparam opcode_t opc_lui    = 7'b011_0111;
  localparam opcode_t opc_jal    = 7'b110_1111;
  localparam opcode_t opc_jalr   = 7'b110_0111;
  localparam opcode_t opc_system = 7'b111_0011;

  // funct3 of addi inside op-imm
  localparam funct3_t f3_addi = 3'b000;

  // full ebreak word, all other fields are fixed
  localparam inst_t ebreak_inst = 32'h0010_0073;

  // decoded operation, one per retired class
  typedef enum logic [2:0] {
    op_addi,
    op_lui,
    op_auipc,
    op_jal,
    op_jalr,
    op_ebreak,
    op_nop
  } op_t;

endpackage

`default_nettype wire

// ==== logic/rv_pc_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_pc_unit (
  input  wire               clk,
  input  wire               reset,
  input  rv_isa_pkg::op_t   op,
  input  wire               jump,
  input  rv_isa_pkg::word_t target,
  output rv_isa_pkg::word_t pc,
  output rv_isa_pkg::word_t pc_plus4,
  output logic              halt
);

  // static next pc, also the link value
  assign pc_plus4 = pc + core_cfg_pkg::inst_bytes;

  // pc and halt flag
  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= core_cfg_pkg::reset_pc;
      halt <= 1'b0;
    end else if (!halt) begin
      if (op == rv_isa_pkg::op_ebreak) begin
        // park on the ebreak until the next reset
        halt <= 1'b1;
      end else if (jump) begin
        pc <= target;
      end else begin
        pc <= pc_plus4;
      end
    end
  end

endmodule

`default_nettype wire

// ==== logic/rv_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_regfile (
  input  wire                  clk,
  input  rv_isa_pkg::reg_idx_t rs1,
  output rv_isa_pkg::word_t    rs1_data,
  input  wire                  wen,
  input  rv_isa_pkg::reg_idx_t waddr,
  input  rv_isa_pkg::word_t    wdata
);

  // register storage, contents undefined after reset
  rv_isa_pkg::word_t regs [core_cfg_pkg::num_regs];

  // x0 target never stored
  logic write_ok;

  assign write_ok = wen && (waddr != '0);

  // single write port on the rising edge
  always_ff @(posedge clk) begin
    if (write_ok) begin
      regs[waddr] <= wdata;
    end
  end

  // asynchronous read, x0 forced to zero
  always_comb begin
    if (rs1 == '0) begin
      rs1_data = '0;
    end else begin
      rs1_data = regs[rs1];
    end
  end

endmodule

`default_nettype wire

// ==== testbench/rv32_core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv32_core_tb;

  // image in words, mirrored every 1 KiB of address space
  localparam int image_words = 256;
  localparam rv_isa_pkg::inst_t ebreak_word = 32'h0010_0073;
  // edges the parked core is watched after halt
  localparam int halt_watch = 6;

  logic              clk;
  logic              reset;
  rv_isa_pkg::inst_t inst;
  rv_isa_pkg::word_t pc;
  logic              halt;

  rv_isa_pkg::inst_t image [image_words];
  int                prog_len;
  int                cycle_limit;
  logic [31:0]       rng;

  // instruction level model, x0 never written
  rv_isa_pkg::word_t model_pc = core_cfg_pkg::reset_pc;
  rv_isa_pkg::word_t model_regs [32] = '{default: '0};
  logic              model_halt = 1'b0;
  int                cycles = 0;
  int                halted_cycles = 0;

  rv32_core uut (
    .clk   (clk),
    .reset (reset),
    .inst  (inst),
    .pc    (pc),
    .halt  (halt)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // random register 1..31
  task automatic pick_reg(output int r);
    rng = xorshift32(rng);
    r = int'(rng % 31) + 1;
  endtask

  function automatic rv_isa_pkg::inst_t itype_word(input rv_isa_pkg::opcode_t opc,
      input logic [31:0] rd, input logic [31:0] f3, input logic [31:0] rs1,
      input logic [31:0] imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic rv_isa_pkg::inst_t utype_word(input rv_isa_pkg::opcode_t opc,
      input logic [31:0] rd, input logic [31:0] imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  // byte offset scrambled into the j format
  function automatic rv_isa_pkg::inst_t jal_word(input logic [31:0] rd,
      input logic [31:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], rv_isa_pkg::opc_jal};
  endfunction

  task automatic put_word(input rv_isa_pkg::inst_t w);
    image[8'(prog_len)] = w;
    prog_len = prog_len + 1;
  endtask

  // word slot from address bits 9:2
  function automatic rv_isa_pkg::inst_t fetch_word(input rv_isa_pkg::word_t addr);
    rv_isa_pkg::word_t offset;
    offset = (addr - core_cfg_pkg::reset_pc) >> 2;
    return image[offset[7:0]];
  endfunction

  task automatic write_reg(input logic [4:0] rd, input rv_isa_pkg::word_t value);
    if (rd != 5'd0) begin
      model_regs[rd] = value;
    end
  endtask

  // one instruction at model_pc by the isa rules
  task automatic step_model();
    rv_isa_pkg::inst_t w;
    rv_isa_pkg::word_t src;
    rv_isa_pkg::word_t imm_i;
    rv_isa_pkg::word_t imm_u;
    rv_isa_pkg::word_t imm_j;
    rv_isa_pkg::word_t link;
    rv_isa_pkg::word_t next_pc;
    w = fetch_word(model_pc);
    src = model_regs[w[19:15]];
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_u = {w[31:12], 12'h000};
    imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    link = model_pc + 32'd4;
    next_pc = link;
    case (w[6:0])
      rv_isa_pkg::opc_op_imm: begin
        // only addi writes, other funct3 retire as nops
        if (w[14:12] == 3'b000) begin
          write_reg(w[11:7], src + imm_i);
        end
      end
      rv_isa_pkg::opc_lui:   write_reg(w[11:7], imm_u);
      rv_isa_pkg::opc_auipc: write_reg(w[11:7], model_pc + imm_u);
      rv_isa_pkg::opc_jal: begin
        write_reg(w[11:7], link);
        next_pc = model_pc + imm_j;
      end
      rv_isa_pkg::opc_jalr: begin
        // target from src read before the link write
        write_reg(w[11:7], link);
        next_pc = (src + imm_i) & ~32'd1;
      end
      rv_isa_pkg::opc_system: begin
        if (w == ebreak_word) begin
          model_halt = 1'b1;
          next_pc = model_pc;
        end
      end
      default: begin
      end
    endcase
    model_pc = next_pc;
  endtask

  task automatic report_mismatch(input string what, input rv_isa_pkg::word_t got,
      input rv_isa_pkg::word_t exp);
    $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    $display("SOME TESTS FAILED");
    $fatal(1, "stopped at the first mismatch");
  endtask

  task automatic build_program();
    int r;
    int rl;
    int rk;
    int acc;
    int a;
    int n;
    // unused words are nop branches tagged with their slot
    for (int i = 0; i < image_words; i++) begin
      image[8'(i)] = (32'(i) << 7) | 32'h0000_0063;
    end
    prog_len = 0;
    // addi chains on a random upper half, out through jalr x0
    for (int k = 0; k < 6; k++) begin
      pick_reg(r);
      rng = xorshift32(rng);
      put_word(utype_word(rv_isa_pkg::opc_lui, r, rng));
      rng = xorshift32(rng);
      n = int'(rng % 3) + 1;
      acc = 0;
      for (int j = 0; j < n; j++) begin
        rng = xorshift32(rng);
        a = int'(rng % 512) - 256;
        acc = acc + a;
        put_word(itype_word(rv_isa_pkg::opc_op_imm, r, 0, r, a));
      end
      // last addi aims past the jalr, bit 0 random
      rng = xorshift32(rng);
      a = 4 * (prog_len + 2) + int'(rng % 2) - acc;
      put_word(itype_word(rv_isa_pkg::opc_op_imm, r, 0, r, a));
      put_word(itype_word(rv_isa_pkg::opc_jalr, 0, 0, r, 0));
    end
    // addi into x0 dropped, jalr through x0 uses its immediate alone
    pick_reg(r);
    rng = xorshift32(rng);
    put_word(itype_word(rv_isa_pkg::opc_op_imm, 0, 0, r, rng));
    put_word(itype_word(rv_isa_pkg::opc_jalr, 0, 0, 0, 4 * (prog_len + 1) + 1));
    // bare lui as base
    pick_reg(r);
    rng = xorshift32(rng);
    put_word(utype_word(rv_isa_pkg::opc_lui, r, rng));
    put_word(itype_word(rv_isa_pkg::opc_jalr, 0, 0, r, 4 * (prog_len + 1)));
    // auipc base, upper part is a multiple of the mirror
    pick_reg(r);
    rng = xorshift32(rng);
    put_word(utype_word(rv_isa_pkg::opc_auipc, r, rng));
    put_word(itype_word(rv_isa_pkg::opc_jalr, 0, 0, r, 8));
    // jal forward over two words, back to a return, then out through both links
    pick_reg(rl);
    rk = rl % 31 + 1;
    put_word(jal_word(rk, 12));
    put_word(itype_word(rv_isa_pkg::opc_jalr, 0, 0, rl, 0));
    prog_len = prog_len + 1;
    put_word(jal_word(rl, -8));
    put_word(itype_word(rv_isa_pkg::opc_jalr, 0, 0, rk, 16));
    // store, branch, ori and ecall leave r untouched
    pick_reg(r);
    rng = xorshift32(rng);
    put_word(utype_word(rv_isa_pkg::opc_lui, r, rng));
    put_word(itype_word(rv_isa_pkg::opc_op_imm, r, 0, r, 4 * (prog_len + 6)));
    put_word({rng[31:12], r[4:0], 7'b010_0011});
    put_word({rng[19:0], r[4:0], 7'b110_0011});
    put_word(itype_word(rv_isa_pkg::opc_op_imm, r, 6, r, rng));
    put_word(32'h0000_0073);
    put_word(itype_word(rv_isa_pkg::opc_jalr, 0, 0, r, 0));
    put_word(ebreak_word);
  endtask

  initial begin
    rng = 32'd7180;
    build_program();
    cycle_limit = 16 + prog_len + 32;
    reset <= 1'b1;
    inst <= fetch_word(core_cfg_pkg::reset_pc);
    repeat (16) @(posedge clk);
    reset <= 1'b0;
  end

  // compare last cycle's state, then step the model and feed its next word
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (!reset) begin
      assert (pc === model_pc)
        else report_mismatch("pc differs from the model", pc, model_pc);
      assert (halt === model_halt)
        else report_mismatch("halt differs from the model", {31'd0, halt}, {31'd0, model_halt});
      if (model_halt) begin
        halted_cycles = halted_cycles + 1;
      end else begin
        step_model();
      end
      inst <= fetch_word(model_pc);
    end
    if (cycles >= cycle_limit) begin
      $display("timeout: core did not reach ebreak within %0d cycles", cycle_limit);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end else if (halted_cycles >= halt_watch) begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== vlog.f ====
logic/rv_isa_pkg.sv
logic/core_cfg_pkg.sv
logic/rv_decode.sv
logic/rv_regfile.sv
logic/rv_execute.sv
logic/rv_pc_unit.sv
logic/rv32_core.sv
testbench/rv32_core_tb.sv
